/* design/mem_access_pkg.sv */
package mem_access_pkg;

   ////////////////////
   // Memory geometry.
   ////////////////////

   localparam int DATA_BITS      = 32;
   localparam int LANES          = 4;
   localparam int BYTE_BITS      = DATA_BITS / LANES;
   localparam int LANE_BITS      = $clog2(LANES);
   localparam int RAM_DEPTH      = 1024;
   localparam int ADDR_BITS      = 12;
   localparam int WORD_ADDR_BITS = ADDR_BITS - LANE_BITS;
   localparam int REG_SEL_BITS   = 5;

   // Load/store width code, laid out like the funct3 field of MIPS loads.
   typedef enum logic [2:0] {
      MEM_BYTE   = 3'b000,
      MEM_HALF   = 3'b001,
      MEM_WORD   = 3'b011,
      MEM_BYTE_U = 3'b100,
      MEM_HALF_U = 3'b101
   } access_width_e;

   ////////////////////
   // Lane helpers.
   ////////////////////

   // True when the low address bits sit on the natural boundary of the width.
   function automatic logic is_aligned(access_width_e width, logic [LANE_BITS-1:0] lsb);
      case (width)
         MEM_HALF, MEM_HALF_U: return ~lsb[0];
         MEM_WORD:             return lsb == '0;
         default:              return 1'b1;
      endcase
   endfunction

   // Picks one byte lane out of a word.
   function automatic logic [BYTE_BITS-1:0] lane_byte(logic [DATA_BITS-1:0] word,
                                                      logic [LANE_BITS-1:0] lane);
      return word[lane*BYTE_BITS +: BYTE_BITS];
   endfunction

endpackage

/* design/debug_access_pkg.sv */
package debug_access_pkg;

   ////////////////////
   // Debug port.
   ////////////////////

   // Who drives the data RAM address.
   typedef enum logic {
      SRC_PIPELINE = 1'b0,
      SRC_DEBUG    = 1'b1
   } addr_source_e;

   // The debug port sees the same byte address and word as the pipeline.
   localparam int DBG_ADDR_BITS = mem_access_pkg::ADDR_BITS;
   localparam int DBG_DATA_BITS = mem_access_pkg::DATA_BITS;

endpackage

/* design/store_lane_decode.sv */
`timescale 1ns/1ps

module store_lane_decode (
   input  mem_access_pkg::access_width_e         i_width,
   input  logic [mem_access_pkg::LANE_BITS-1:0]  i_addr_lsb,
   input  logic [mem_access_pkg::DATA_BITS-1:0]  i_store_data,
   output logic [mem_access_pkg::LANES-1:0]      o_byte_enable,
   output logic [mem_access_pkg::DATA_BITS-1:0]  o_lane_data
);

   ////////////////////
   // Lane decode.
   ////////////////////

   // The store value is repeated into every lane, the enables pick the bytes that land.
   always_comb begin
      o_byte_enable = '0;
      o_lane_data   = i_store_data;
      case (i_width)
         mem_access_pkg::MEM_BYTE, mem_access_pkg::MEM_BYTE_U: begin
            o_byte_enable[i_addr_lsb] = 1'b1;
            o_lane_data = {mem_access_pkg::LANES{
               i_store_data[mem_access_pkg::BYTE_BITS-1:0]}};
         end
         mem_access_pkg::MEM_HALF, mem_access_pkg::MEM_HALF_U: begin
            // Upper pair when address bit 1 is set.
            if (i_addr_lsb[1]) begin
               o_byte_enable = 4'b1100;
            end else begin
               o_byte_enable = 4'b0011;
            end
            o_lane_data = {(mem_access_pkg::LANES / 2){
               i_store_data[2*mem_access_pkg::BYTE_BITS-1:0]}};
         end
         mem_access_pkg::MEM_WORD: begin
            o_byte_enable = '1;
         end
         default: begin
            o_byte_enable = '0;
         end
      endcase
   end

   ////////////////////
   // Checks.
   ////////////////////

   // Misaligned halfword and word accesses are not supported by the stage.
   always_comb begin
      if (o_byte_enable != '0) begin
         assert final (mem_access_pkg::is_aligned(i_width, i_addr_lsb))
            else $error("misaligned %s access at lane %0d", i_width.name(), i_addr_lsb);
      end
   end

endmodule

/* design/data_memory.sv */
`timescale 1ns/1ps

module data_memory (
   input  logic                                       i_clock,
   input  logic                                       i_mem_enable,
   input  logic [mem_access_pkg::WORD_ADDR_BITS-1:0]  i_word_addr,
   input  logic [mem_access_pkg::LANES-1:0]           i_byte_enable,
   input  logic [mem_access_pkg::DATA_BITS-1:0]       i_write_data,
   output logic [mem_access_pkg::DATA_BITS-1:0]       o_read_data
);

   ////////////////////
   // Storage.
   ////////////////////

   // Word organised, one column per byte lane.
   logic [mem_access_pkg::DATA_BITS-1:0] ram [mem_access_pkg::RAM_DEPTH];

   // Per-lane writes.
   always_ff @(posedge i_clock) begin
      if (i_mem_enable) begin
         for (int lane = 0; lane < mem_access_pkg::LANES; lane++) begin
            if (i_byte_enable[lane]) begin
               ram[i_word_addr][lane*mem_access_pkg::BYTE_BITS +: mem_access_pkg::BYTE_BITS]
                  <= i_write_data[lane*mem_access_pkg::BYTE_BITS +: mem_access_pkg::BYTE_BITS];
            end
         end
      end
   end

   ////////////////////
   // Read port.
   ////////////////////

   // Read-first, so a write in the same cycle shows up one access later.
   always_ff @(posedge i_clock) begin
      if (i_mem_enable) begin
         o_read_data <= ram[i_word_addr];
      end
   end

   ////////////////////
   // Checks.
   ////////////////////

   // A disabled cycle leaves the read word untouched for the load formatter.
   assert property (@(posedge i_clock) !i_mem_enable |=> $stable(o_read_data))
      else $error("read word changed while the RAM was disabled");

endmodule

/* design/dirty_word_tracker.sv */
`timescale 1ns/1ps

module dirty_word_tracker (
   input  logic                                       i_clock,
   input  logic                                       i_soft_reset,
   input  logic                                       i_mem_enable,
   input  logic [mem_access_pkg::WORD_ADDR_BITS-1:0]  i_word_addr,
   input  logic [mem_access_pkg::LANES-1:0]           i_byte_enable,
   output logic                                       o_dirty
);

   // One bit per RAM word.
   logic [mem_access_pkg::RAM_DEPTH-1:0] dirty_bits;

   ////////////////////
   // Tracking.
   ////////////////////

   // The bit is sampled before this cycle's write marks it.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         dirty_bits <= '0;
         o_dirty    <= 1'b0;
      end else if (i_mem_enable) begin
         o_dirty <= dirty_bits[i_word_addr];
         if (|i_byte_enable) begin
            dirty_bits[i_word_addr] <= 1'b1;
         end
      end
   end

   ////////////////////
   // Checks.
   ////////////////////

   // Nothing reads as dirty right after a reset.
   assert property (@(posedge i_clock) !i_soft_reset |=> !o_dirty)
      else $error("dirty bit set in the cycle after reset");

endmodule

/* design/load_result_format.sv */
`timescale 1ns/1ps

module load_result_format (
   input  logic                                  i_clock,
   input  logic                                  i_mem_enable,
   input  logic [mem_access_pkg::DATA_BITS-1:0]  i_read_data,
   input  mem_access_pkg::access_width_e         i_width,
   input  logic [mem_access_pkg::LANE_BITS-1:0]  i_addr_lsb,
   output logic [mem_access_pkg::DATA_BITS-1:0]  o_load_data
);

   mem_access_pkg::access_width_e              width_q;
   logic [mem_access_pkg::LANE_BITS-1:0]       lsb_q;
   logic [mem_access_pkg::BYTE_BITS-1:0]       sel_byte;
   logic [2*mem_access_pkg::BYTE_BITS-1:0]     sel_half;

   // Width and lane follow the registered RAM read.
   always_ff @(posedge i_clock) begin
      if (i_mem_enable) begin
         width_q <= i_width;
         lsb_q   <= i_addr_lsb;
      end
   end

   ////////////////////
   // Lane select.
   ////////////////////

   assign sel_byte = mem_access_pkg::lane_byte(i_read_data, lsb_q);
   assign sel_half = lsb_q[1] ? i_read_data[mem_access_pkg::DATA_BITS-1 -: 2*mem_access_pkg::BYTE_BITS]
                              : i_read_data[0 +: 2*mem_access_pkg::BYTE_BITS];

   // Sign or zero extension.
   always_comb begin
      case (width_q)
         mem_access_pkg::MEM_BYTE:
            o_load_data = {{(mem_access_pkg::DATA_BITS - mem_access_pkg::BYTE_BITS)
                            {sel_byte[mem_access_pkg::BYTE_BITS-1]}}, sel_byte};
         mem_access_pkg::MEM_BYTE_U:
            o_load_data = {{(mem_access_pkg::DATA_BITS - mem_access_pkg::BYTE_BITS)
                            {1'b0}}, sel_byte};
         mem_access_pkg::MEM_HALF:
            o_load_data = {{(mem_access_pkg::DATA_BITS - 2*mem_access_pkg::BYTE_BITS)
                            {sel_half[2*mem_access_pkg::BYTE_BITS-1]}}, sel_half};
         mem_access_pkg::MEM_HALF_U:
            o_load_data = {{(mem_access_pkg::DATA_BITS - 2*mem_access_pkg::BYTE_BITS)
                            {1'b0}}, sel_half};
         default:
            o_load_data = i_read_data;
      endcase
   end

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
   input  logic                                         i_clock,
   input  logic                                         i_soft_reset,
   input  logic                                         i_enable_pipeline,
   input  logic                                         i_mem_enable,
   input  debug_access_pkg::addr_source_e               i_addr_source,
   input  logic [debug_access_pkg::DBG_ADDR_BITS-1:0]   i_debug_addr,
   input  logic [mem_access_pkg::DATA_BITS-1:0]         i_alu_result,
   input  logic [mem_access_pkg::DATA_BITS-1:0]         i_store_data,
   input  mem_access_pkg::access_width_e                i_width,
   input  logic                                         i_mem_read,
   input  logic                                         i_mem_write,
   input  logic                                         i_reg_write,
   input  logic                                         i_mem_to_reg,
   input  logic [mem_access_pkg::REG_SEL_BITS-1:0]      i_dest_reg,
   input  logic                                         i_halt_detected,
   output logic                                         o_reg_write,
   output logic                                         o_mem_to_reg,
   output logic [mem_access_pkg::REG_SEL_BITS-1:0]      o_dest_reg,
   output logic                                         o_halt_detected,
   output logic [mem_access_pkg::DATA_BITS-1:0]         o_alu_data,
   output logic [mem_access_pkg::DATA_BITS-1:0]         o_load_data,
   output logic [debug_access_pkg::DBG_DATA_BITS-1:0]   o_debug_data,
   output logic                                         o_debug_dirty
);

   logic [mem_access_pkg::ADDR_BITS-1:0]       mem_addr;
   logic [mem_access_pkg::WORD_ADDR_BITS-1:0]  word_addr;
   logic [mem_access_pkg::LANES-1:0]           lane_enable;
   logic [mem_access_pkg::LANES-1:0]           write_enable;
   logic [mem_access_pkg::DATA_BITS-1:0]       lane_data;
   logic [mem_access_pkg::DATA_BITS-1:0]       read_word;
   logic [mem_access_pkg::DATA_BITS-1:0]       load_word;
   logic                                       write_allowed;

   ////////////////////
   // Address and write gating.
   ////////////////////

   assign mem_addr  = (i_addr_source == debug_access_pkg::SRC_DEBUG) ? i_debug_addr
                                                 : i_alu_result[mem_access_pkg::ADDR_BITS-1:0];
   assign word_addr = mem_addr[mem_access_pkg::ADDR_BITS-1:mem_access_pkg::LANE_BITS];

   // The debug unit only ever reads.
   assign write_allowed = i_mem_write && i_mem_enable &&
                          (i_addr_source == debug_access_pkg::SRC_PIPELINE);
   assign write_enable  = write_allowed ? lane_enable : '0;

   store_lane_decode store_lane_decode_inst (
      .i_width       (i_width),
      .i_addr_lsb    (mem_addr[mem_access_pkg::LANE_BITS-1:0]),
      .i_store_data  (i_store_data),
      .o_byte_enable (lane_enable),
      .o_lane_data   (lane_data)
   );

   data_memory data_memory_inst (
      .i_clock       (i_clock),
      .i_mem_enable  (i_mem_enable),
      .i_word_addr   (word_addr),
      .i_byte_enable (write_enable),
      .i_write_data  (lane_data),
      .o_read_data   (read_word)
   );

   dirty_word_tracker dirty_word_tracker_inst (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_mem_enable  (i_mem_enable),
      .i_word_addr   (word_addr),
      .i_byte_enable (write_enable),
      .o_dirty       (o_debug_dirty)
   );

   load_result_format load_result_format_inst (
      .i_clock      (i_clock),
      .i_mem_enable (i_mem_enable),
      .i_read_data  (read_word),
      .i_width      (i_width),
      .i_addr_lsb   (mem_addr[mem_access_pkg::LANE_BITS-1:0]),
      .o_load_data  (load_word)
   );

   assign o_debug_data = read_word;

   ////////////////////
   // MEM/WB register.
   ////////////////////

   // Falling edge capture, held while the pipeline is stalled.
   always_ff @(negedge i_clock) begin
      if (!i_soft_reset) begin
         o_reg_write     <= 1'b0;
         o_mem_to_reg    <= 1'b0;
         o_dest_reg      <= '0;
         o_halt_detected <= 1'b0;
         o_alu_data      <= '0;
         o_load_data     <= '0;
      end else if (i_enable_pipeline) begin
         o_reg_write     <= i_reg_write;
         o_mem_to_reg    <= i_mem_to_reg;
         o_dest_reg      <= i_dest_reg;
         o_halt_detected <= i_halt_detected;
         o_alu_data      <= i_alu_result;
         o_load_data     <= load_word;
      end
   end

   // Decode never issues a load and a store together.
   assert property (@(posedge i_clock) disable iff (!i_soft_reset)
                    !(i_mem_read && i_mem_write))
      else $error("load and store requested in the same cycle");

endmodule

/* verification/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;

   // Cycles per test, with the reset at the start and the flush at the end.
   localparam int RUN_CYCLES = 3 + 16 + 20 + 52 + 20 + 39 + 8 + 2;
   localparam int CYCLE_LIMIT = 2 * RUN_CYCLES;

   logic clk = 0, i_soft_reset, i_enable_pipeline, i_mem_enable, i_mem_read, i_mem_write;
   logic i_reg_write, i_mem_to_reg, i_halt_detected, o_reg_write, o_mem_to_reg;
   logic o_halt_detected, o_debug_dirty, tick = 0;
   debug_access_pkg::addr_source_e i_addr_source;
   mem_access_pkg::access_width_e i_width;
   logic [11:0] i_debug_addr;
   logic [31:0] i_alu_result, i_store_data, o_alu_data, o_load_data, o_debug_data;
   logic [4:0] i_dest_reg, o_dest_reg;

   // Reference model, one entry per byte address.
   logic [7:0] model_mem [4096];
   logic model_known [4096];
   logic model_dirty [1024];
   logic [31:0] lfsr_state = 32'h313d0913;
   logic [11:0] written [$];
   int errors = 0, cycles = 0, tests = 0, failed = 0;

   // Results expected one capture later, then what the MEM/WB register holds now.
   logic p_rst = 1, p_en = 0, p_known, p_chk_dbg = 0, p_dirty;
   logic [31:0] p_alu, p_load, p_dbg;
   logic [7:0] p_ctrl;
   logic started = 0, cap_known = 0, cur_known = 0, chk_dbg = 0, cur_dirty;
   logic [31:0] cap_alu, cap_load, cur_dbg;
   logic [7:0] cap_ctrl;

   mem_stage mem_stage_inst (.i_clock(clk), .*);

   initial begin
      forever #20 clk = ~clk;
   end

   always @(negedge clk) begin
      #1 tick = 1;
      #1 tick = 0;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   ////////////////////
   // Checks.
   ////////////////////

   assert property (@(posedge tick) started |-> o_alu_data == cap_alu)
      else begin
         $display("mismatch at %0t: alu data %h, expected %h", $time, o_alu_data, cap_alu);
         errors++;
      end
   assert property (@(posedge tick) started |->
                    {o_reg_write, o_mem_to_reg, o_dest_reg, o_halt_detected} == cap_ctrl)
      else begin
         $display("mismatch at %0t: control fields wrong", $time);
         errors++;
      end
   assert property (@(posedge tick) started && cap_known |-> o_load_data == cap_load)
      else begin
         $display("mismatch at %0t: load %h, expected %h", $time, o_load_data, cap_load);
         errors++;
      end
   assert property (@(posedge tick) chk_dbg && cur_known |-> o_debug_data == cur_dbg)
      else begin
         $display("mismatch at %0t: debug word %h, expected %h", $time, o_debug_data,
                  cur_dbg);
         errors++;
      end
   assert property (@(posedge tick) chk_dbg |-> o_debug_dirty == cur_dirty)
      else begin
         $display("mismatch at %0t: dirty bit %b, expected %b", $time, o_debug_dirty,
                  cur_dirty);
         errors++;
      end

   // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit.
   function automatic logic [31:0] take_bits(int n);
      logic [31:0] r;
      logic fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   // Load result from the model bytes, extended as the width code says.
   function automatic logic [31:0] expected_load(logic [11:0] addr, logic [2:0] width);
      logic [7:0] b;
      logic [15:0] h;
      b = model_mem[addr];
      h = {model_mem[{addr[11:1], 1'b1}], model_mem[{addr[11:1], 1'b0}]};
      case (width)
         3'b000:  return {{24{b[7]}}, b};
         3'b100:  return {24'd0, b};
         3'b001:  return {{16{h[15]}}, h};
         3'b101:  return {16'd0, h};
         default: return {model_mem[{addr[11:2], 2'd3}], model_mem[{addr[11:2], 2'd2}],
                          model_mem[{addr[11:2], 2'd1}], model_mem[{addr[11:2], 2'd0}]};
      endcase
   endfunction

   // One clock: take over what the DUT just captured, then drive the next access.
   task automatic drive(logic rst_n, logic en, logic src, logic [11:0] addr,
                        logic [31:0] data, logic [2:0] width, logic wr, logic dbg);
      logic [9:0] w;
      logic [7:0] ctrl;
      logic [31:0] alu;
      int first;
      int count;
      w = addr[11:2];
      ctrl = take_bits(8);
      alu = src ? take_bits(32) : {take_bits(20), addr};
      @(negedge clk);
      if (!p_rst) begin
         started = 1;
         {cap_alu, cap_load, cap_ctrl, cap_known} = '0;
         cap_known = 1;
      end else if (p_en) begin
         {cap_alu, cap_load, cap_ctrl, cap_known} = {p_alu, p_load, p_ctrl, p_known};
      end
      {cur_dbg, cur_dirty, cur_known, chk_dbg} = {p_dbg, p_dirty, p_known, p_chk_dbg};
      i_soft_reset <= rst_n;
      i_enable_pipeline <= en;
      i_addr_source <= debug_access_pkg::addr_source_e'(src);
      i_debug_addr <= addr;
      i_alu_result <= alu;
      i_store_data <= data;
      i_width <= mem_access_pkg::access_width_e'(width);
      i_mem_write <= wr;
      i_mem_read <= !wr;
      {i_reg_write, i_mem_to_reg, i_dest_reg, i_halt_detected} <= ctrl;
      // Read-first, so the expectations come from the model before this write.
      p_known = model_known[{w, 2'd0}] && model_known[{w, 2'd1}]
                && model_known[{w, 2'd2}] && model_known[{w, 2'd3}];
      p_dbg = expected_load({w, 2'd0}, 3'b011);
      p_load = expected_load(addr, width);
      p_dirty = model_dirty[w];
      {p_alu, p_ctrl, p_rst, p_en, p_chk_dbg} = {alu, ctrl, rst_n, en, dbg && rst_n};
      if (!rst_n) begin
         foreach (model_dirty[i]) model_dirty[i] = 0;
      end
      if (wr && !src) begin
         first = (width[1:0] == 2'b11) ? 0 : addr[1:0];
         count = (width[1:0] == 2'b11) ? 4 : (width[0] ? 2 : 1);
         for (int i = 0; i < count; i++) begin
            model_mem[{w, 2'(first + i)}] = data[8*i +: 8];
            model_known[{w, 2'(first + i)}] = 1;
         end
         if (rst_n) model_dirty[w] = 1;
      end
   endtask

   task automatic report_test(string name, int errors_before);
      tests++;
      if (errors != errors_before) failed++;
      $display("%s: %s", name, (errors == errors_before) ? "pass" : "fail");
   endtask

   initial begin
      logic [11:0] a;
      logic [31:0] d;
      int e;
      {i_soft_reset, i_enable_pipeline, i_mem_enable, i_mem_read, i_mem_write} = 5'b00100;
      {i_reg_write, i_mem_to_reg, i_halt_detected, i_dest_reg} = '0;
      {i_debug_addr, i_alu_result, i_store_data} = '0;
      i_addr_source = debug_access_pkg::SRC_PIPELINE;
      i_width = mem_access_pkg::MEM_WORD;
      foreach (model_known[i]) model_known[i] = 0;
      foreach (model_dirty[i]) model_dirty[i] = 0;
      repeat (3) drive(0, 1, 0, 0, 0, 3'b011, 0, 0);

      /////////////////////
      // Stores and loads.
      /////////////////////
      e = errors;
      repeat (8) begin
         a = {1'b0, take_bits(9), 2'b00};
         written.push_back(a);
         drive(1, 1, 0, a, take_bits(32), 3'b011, 1, 0);
         drive(1, 1, 0, a, 0, 3'b011, 0, 0);
      end
      report_test("word store and load", e);

      e = errors;
      repeat (4) begin
         a = {1'b0, take_bits(9), 2'b00};
         written.push_back(a);
         drive(1, 1, 0, a, take_bits(32), 3'b000, 1, 0);
         drive(1, 1, 0, a + 1, take_bits(32), 3'b000, 1, 0);
         drive(1, 1, 0, a + 2, take_bits(32), 3'b001, 1, 0);
         drive(1, 1, 0, a, 0, 3'b011, 0, 0);
         drive(1, 1, 1, a, 0, 3'b011, 0, 1);
      end
      report_test("byte and halfword merge", e);

      e = errors;
      repeat (4) begin
         a = {1'b0, take_bits(9), 2'b00};
         written.push_back(a);
         drive(1, 1, 0, a, take_bits(32) | 32'h8080_8080, 3'b011, 1, 0);
         for (int l = 0; l < 4; l++) begin
            drive(1, 1, 0, a + l, 0, 3'b000, 0, 0);
            drive(1, 1, 0, a + l, 0, 3'b100, 0, 0);
         end
         for (int l = 0; l < 4; l += 2) begin
            drive(1, 1, 0, a + l, 0, 3'b001, 0, 0);
            drive(1, 1, 0, a + l, 0, 3'b101, 0, 0);
         end
      end
      report_test("signed and unsigned loads", e);

      e = errors;
      repeat (2) begin
         repeat (6) drive(1, 0, 0, written[take_bits(3)], take_bits(32), 3'b011, 0, 0);
         repeat (4) drive(1, 1, 0, written[take_bits(3)], 0, 3'b011, 0, 0);
      end
      report_test("pipeline stall", e);

      /////////////////////
      // Debug port.
      /////////////////////
      e = errors;
      foreach (written[i]) drive(1, 1, 1, written[i], 0, 3'b011, 0, 1);
      repeat (4) drive(1, 1, 1, {1'b1, take_bits(9), 2'b00}, 0, 3'b011, 0, 1);
      repeat (3) drive(0, 1, 1, 0, 0, 3'b011, 0, 0);
      foreach (written[i]) drive(1, 1, 1, written[i], 0, 3'b011, 0, 1);
      report_test("dirty bits and reset", e);

      e = errors;
      repeat (4) begin
         a = written[take_bits(4)];
         d = take_bits(32);
         drive(1, 1, 1, a, d, 3'b011, 1, 1);
         drive(1, 1, 1, a, 0, 3'b011, 0, 1);
      end
      report_test("debug store blocked", e);

      repeat (2) drive(1, 1, 0, 0, 0, 3'b011, 0, 0);
      #5;
      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* build.f */
design/mem_access_pkg.sv
design/debug_access_pkg.sv
design/store_lane_decode.sv
design/data_memory.sv
design/dirty_word_tracker.sv
design/load_result_format.sv
design/mem_stage.sv
verification/mem_stage_tb.sv
